/* burst_cache.f */
src/burst_cache_pkg.sv
src/line_ram.sv
src/cache_controller.sv
src/burst_sequencer.sv
src/burst_cache.sv
test/burst_ram_model.sv
test/burst_cache_tb.sv

/* src/burst_cache.sv */
// Burst cache top level
// Direct-mapped write-back cache for a 32-bit requester; joins the
// controller and the burst sequencer over the job channel

`default_nettype none

module burst_cache (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire burst_cache_pkg::cache_req_t  req,
  input  wire                          req_valid,
  output logic                         req_ready,
  output burst_cache_pkg::word_t       rsp_rdata,
  output burst_cache_pkg::br_cmd_t     br_cmd,
  output logic                         br_cmd_en,
  output burst_cache_pkg::beat_t       br_wr_data,
  output logic [7:0]                   br_data_mask,
  input  wire burst_cache_pkg::beat_t  br_rd_data,
  input  wire                          br_rd_data_valid
);
  import burst_cache_pkg::*;

  burst_job_t job;
  logic job_valid;
  logic job_ready;
  logic fill_valid;
  line_t fill_line;
  logic wb_done;

  cache_controller u_ctrl (
    .clk,
    .rst_n,
    .req,
    .req_valid,
    .req_ready,
    .rsp_rdata,
    .job,
    .job_valid,
    .job_ready,
    .fill_valid,
    .fill_line,
    .wb_done
  );

  burst_sequencer u_seq (
    .clk,
    .rst_n,
    .job,
    .job_valid,
    .job_ready,
    .fill_valid,
    .fill_line,
    .wb_done,
    .br_cmd,
    .br_cmd_en,
    .br_wr_data,
    .br_data_mask,
    .br_rd_data,
    .br_rd_data_valid
  );

endmodule

`default_nettype wire

/* src/burst_cache_pkg.sv */
// Burst cache shared definitions
// Sizes, vector types, channel structs and FSM encodings for the
// direct-mapped write-back cache in front of a burst RAM

`default_nettype none

package burst_cache_pkg;

  // 64 lines of 8 words each
  localparam int line_ix_w = 6;
  localparam int col_ix_w = 3;
  localparam int col_count = 8;

  // the two low address bits of the byte addressed burst RAM select the byte
  localparam int ram_addr_w = 21;
  localparam int tag_w = ram_addr_w - line_ix_w - col_ix_w - 2;

  // one burst moves a whole line as 64-bit beats
  localparam int beats_per_line = 4;

  // idle cycles reloaded into the interval counter per command
  localparam int cmd_interval = 13;
  localparam int gap_w = $clog2(cmd_interval + 1);

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [63:0] beat_t;
  typedef logic [255:0] line_t;
  typedef logic [line_ix_w-1:0] line_ix_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [ram_addr_w-1:0] ram_addr_t;

  // wstrb of zero marks a read
  typedef struct packed {
    logic [31:0] addr;
    word_t wdata;
    strb_t wstrb;
  } cache_req_t;

  typedef struct packed {
    logic write;
    ram_addr_t addr;
    line_t line;
  } burst_job_t;

  typedef struct packed {
    logic write;
    ram_addr_t addr;
  } br_cmd_t;

  typedef enum logic [1:0] {
    ctrl_lookup,
    ctrl_evict,
    ctrl_fill,
    ctrl_install
  } ctrl_state_e;

  typedef enum logic [2:0] {
    seq_idle,
    seq_send,
    seq_wait_data,
    seq_receive,
    seq_done
  } seq_state_e;

endpackage

`default_nettype wire

/* src/burst_sequencer.sv */
// Burst sequencer
// Issues one burst RAM command per job, keeps the minimum command interval,
// streams a victim line out as beats and assembles fill beats into a line

`default_nettype none

module burst_sequencer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire burst_cache_pkg::burst_job_t  job,
  input  wire                          job_valid,
  output logic                         job_ready,
  output logic                         fill_valid,
  output burst_cache_pkg::line_t       fill_line,
  output logic                         wb_done,
  output burst_cache_pkg::br_cmd_t     br_cmd,
  output logic                         br_cmd_en,
  output burst_cache_pkg::beat_t       br_wr_data,
  output logic [7:0]                   br_data_mask,
  input  wire burst_cache_pkg::beat_t  br_rd_data,
  input  wire                          br_rd_data_valid
);
  import burst_cache_pkg::*;

  seq_state_e state;
  burst_job_t job_q;
  logic [1:0] beat_cnt;
  logic [gap_w-1:0] gap_cnt;
  logic last_beat;

  assign job_ready = state == seq_idle && gap_cnt == '0;
  assign br_cmd_en = state == seq_send && beat_cnt == '0;
  assign br_cmd = {job_q.write, job_q.addr};
  // low beat of the shifting victim line
  assign br_wr_data = job_q.line[$bits(beat_t)-1:0];
  assign br_data_mask = '0;
  assign fill_valid = state == seq_done && !job_q.write;
  assign wb_done = state == seq_done && job_q.write;
  assign last_beat = beat_cnt == 2'(beats_per_line - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= seq_idle;
      beat_cnt <= '0;
      // job_ready stays low through reset and one interval after it
      gap_cnt <= gap_w'(cmd_interval);
    end else begin
      if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      case (state)
        seq_idle: begin
          if (job_valid && job_ready) begin
            state <= seq_send;
          end
        end
        seq_send: begin
          if (beat_cnt == '0) begin
            gap_cnt <= gap_w'(cmd_interval);
          end
          // write beats leave back to back from the command cycle
          if (!job_q.write) begin
            state <= seq_wait_data;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= seq_done;
            end
          end
        end
        seq_wait_data: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            state <= seq_receive;
          end
        end
        seq_receive: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= seq_done;
            end
          end
        end
        seq_done: state <= seq_idle;
        default: state <= seq_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (job_valid && job_ready) begin
      job_q <= job;
    end else if (state == seq_send && job_q.write) begin
      job_q.line <= job_q.line >> $bits(beat_t);
    end
    // beats enter at the top so beat 0 ends in columns 0 and 1
    if (br_rd_data_valid && state inside {seq_wait_data, seq_receive}) begin
      fill_line <= {br_rd_data, fill_line[$bits(line_t)-1:$bits(beat_t)]};
    end
  end

  a_cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> gap_cnt == '0);

  a_no_idle_data: assert property (@(posedge clk) disable iff (!rst_n)
    state == seq_idle |-> !br_rd_data_valid);

endmodule

`default_nettype wire

/* src/cache_controller.sv */
// Cache controller
// Splits the request address, looks up tag and column RAMs, serves hits,
// and on a miss requests a write-back of a dirty victim and a line fill

`default_nettype none

module cache_controller (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire burst_cache_pkg::cache_req_t  req,
  input  wire                          req_valid,
  output logic                         req_ready,
  output burst_cache_pkg::word_t       rsp_rdata,
  output burst_cache_pkg::burst_job_t  job,
  output logic                         job_valid,
  input  wire                          job_ready,
  input  wire                          fill_valid,
  input  wire burst_cache_pkg::line_t  fill_line,
  input  wire                          wb_done
);
  import burst_cache_pkg::*;

  ctrl_state_e state;
  logic clearing;
  line_ix_t clr_ix;
  logic rd_valid;
  logic read_pending;

  tag_t req_tag;
  line_ix_t req_ix;
  logic [col_ix_w-1:0] req_col;

  word_t tag_rdata;
  word_t tag_wdata;
  strb_t tag_we;
  line_ix_t tag_addr;
  tag_t stored_tag;
  logic stored_valid;
  logic stored_dirty;

  word_t col_rdata [col_count];
  line_t victim_line;

  logic hit;
  logic miss;
  logic is_write;
  logic accept;
  logic victim_dirty;

  // |tag|line|col|00|
  assign req_tag = req.addr[2+col_ix_w+line_ix_w +: tag_w];
  assign req_ix = req.addr[2+col_ix_w +: line_ix_w];
  assign req_col = req.addr[2 +: col_ix_w];

  // tag word holds {dirty, valid, tag}
  assign stored_tag = tag_rdata[tag_w-1:0];
  assign stored_valid = tag_rdata[tag_w];
  assign stored_dirty = tag_rdata[tag_w+1];

  // rd_valid says the RAM outputs belong to the request now presented
  assign hit = rd_valid && stored_valid && stored_tag == req_tag;
  assign miss = !clearing && state == ctrl_lookup && rd_valid && !hit;
  assign is_write = req.wstrb != '0;
  assign req_ready = !clearing && state == ctrl_lookup && hit;
  assign accept = req_valid && req_ready;
  assign victim_dirty = state == ctrl_lookup && stored_valid && stored_dirty;

  assign rsp_rdata = col_rdata[req_col];

  line_ram u_tag (
    .clk,
    .we(tag_we),
    .addr(tag_addr),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  always_comb begin
    tag_addr = req_ix;
    tag_we = '0;
    tag_wdata = '0;
    if (clearing) begin
      tag_addr = clr_ix;
      tag_we = '1;
    end else if (state == ctrl_install) begin
      tag_we = '1;
      tag_wdata = word_t'({1'b0, 1'b1, req_tag});
    end else if (accept && is_write) begin
      // write hit marks the line dirty
      tag_we = '1;
      tag_wdata = word_t'({1'b1, 1'b1, req_tag});
    end
  end

  for (genvar i = 0; i < col_count; i++) begin : gen_col
    strb_t col_we;
    word_t col_wdata;

    always_comb begin
      if (state == ctrl_install) begin
        col_we = '1;
        col_wdata = fill_line[$bits(word_t)*i +: $bits(word_t)];
      end else begin
        col_we = (accept && is_write && req_col == col_ix_w'(i)) ? req.wstrb : '0;
        col_wdata = req.wdata;
      end
    end

    line_ram u_col (
      .clk,
      .we(col_we),
      .addr(req_ix),
      .wdata(col_wdata),
      .rdata(col_rdata[i])
    );
  end

  always_comb begin
    for (int i = 0; i < col_count; i++) begin
      victim_line[$bits(word_t)*i +: $bits(word_t)] = col_rdata[i];
    end
  end

  // dirty victim goes out first and the read job follows from the fill state
  always_comb begin
    job.write = victim_dirty;
    job.addr = victim_dirty ? {stored_tag, req_ix, {(col_ix_w + 2){1'b0}}}
                            : {req_tag, req_ix, {(col_ix_w + 2){1'b0}}};
    job.line = victim_line;
  end

  assign job_valid = miss || (state == ctrl_fill && read_pending);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ctrl_lookup;
      clearing <= 1'b1;
      clr_ix <= '0;
      rd_valid <= 1'b0;
      read_pending <= 1'b0;
    end else begin
      rd_valid <= req_valid && !accept && !clearing && state == ctrl_lookup;
      // invalidate every tag entry once after reset
      if (clearing) begin
        clr_ix <= clr_ix + 1'b1;
        if (clr_ix == '1) begin
          clearing <= 1'b0;
        end
      end
      case (state)
        ctrl_lookup: begin
          if (job_valid && job_ready) begin
            state <= victim_dirty ? ctrl_evict : ctrl_fill;
          end
        end
        ctrl_evict: begin
          if (wb_done) begin
            state <= ctrl_fill;
            read_pending <= 1'b1;
          end
        end
        ctrl_fill: begin
          if (job_valid && job_ready) begin
            read_pending <= 1'b0;
          end
          if (fill_valid) begin
            state <= ctrl_install;
          end
        end
        ctrl_install: state <= ctrl_lookup;
        default: state <= ctrl_lookup;
      endcase
    end
  end

  // a write-back only completes while its victim is out
  a_wb_in_evict: assert property (@(posedge clk) disable iff (!rst_n)
    wb_done |-> state == ctrl_evict);

  // a fill only lands after its read job has been taken
  a_fill_expected: assert property (@(posedge clk) disable iff (!rst_n)
    fill_valid |-> state == ctrl_fill && !read_pending);

endmodule

`default_nettype wire

/* src/line_ram.sv */
// Line RAM
// Single-port storage of one 32-bit word per cache line, with byte write
// enables and a registered read that returns the old word on a write

`default_nettype none

module line_ram (
  input  wire                       clk,
  input  wire burst_cache_pkg::strb_t    we,
  input  wire burst_cache_pkg::line_ix_t addr,
  input  wire burst_cache_pkg::word_t    wdata,
  output burst_cache_pkg::word_t         rdata
);
  import burst_cache_pkg::*;

  word_t mem [2**line_ix_w];

  always_ff @(posedge clk) begin
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (we[b]) begin
        mem[addr][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* test/burst_cache_tb.sv */
// Burst cache testbench
// Runs directed and random requests against the cache, predicts data from
// a reference memory and cache residency from a shadow tag array

`default_nettype none

module burst_cache_tb;
  import burst_cache_pkg::*;

  localparam int random_requests = 200;
  localparam int total_requests = 7 + random_requests;
  localparam int watchdog_cycles = total_requests * 60 + 200;

  logic clk;
  logic rst_n;
  cache_req_t req;
  logic req_valid;
  logic req_ready;
  word_t rsp_rdata;
  br_cmd_t br_cmd;
  logic br_cmd_en;
  beat_t br_wr_data;
  logic [7:0] br_data_mask;
  beat_t br_rd_data;
  logic br_rd_data_valid;
  int spacing_errors;

  word_t ref_mem [int unsigned];
  tag_t shadow_tag [2**line_ix_w];
  logic shadow_valid [2**line_ix_w];
  logic shadow_dirty [2**line_ix_w];

  word_t exp_rdata;
  int exp_rd;
  int exp_wr;
  ram_addr_t exp_line;
  ram_addr_t exp_victim;
  int rd_cnt;
  int wr_cnt;
  logic accept_q;
  int sweep_cnt;
  int errors;
  int tests_run;
  int tests_bad;
  int errs_before;

  burst_cache UUT (
    .clk,
    .rst_n,
    .req,
    .req_valid,
    .req_ready,
    .rsp_rdata,
    .br_cmd,
    .br_cmd_en,
    .br_wr_data,
    .br_data_mask,
    .br_rd_data,
    .br_rd_data_valid
  );

  burst_ram_model u_ram (
    .clk,
    .rst_n,
    .br_cmd,
    .br_cmd_en,
    .br_wr_data,
    .br_data_mask,
    .br_rd_data,
    .br_rd_data_valid,
    .spacing_errors
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // the same hash the RAM is loaded with
  function automatic word_t prefill_word(input int unsigned w);
    return (w * 32'h9e3779b1) ^ (w << 11) ^ 32'h5a5a0000;
  endfunction

  function automatic word_t ref_word(input int unsigned w);
    if (ref_mem.exists(w)) begin
      return ref_mem[w];
    end
    return prefill_word(w);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t s);
    word_t r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        r[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return r;
  endfunction

  // a few tags over the same few lines so that misses conflict
  function automatic logic [31:0] random_address();
    logic [31:0] a;
    a = '0;
    a[20:11] = tag_t'($urandom_range(0, 2));
    a[10:5] = line_ix_t'($urandom_range(0, 3));
    a[4:2] = 3'($urandom_range(0, 7));
    return a;
  endfunction

  function automatic int total_errors();
    return errors + spacing_errors;
  endfunction

  // per-request command counts are cleared at each handshake
  always @(posedge clk) begin
    accept_q <= req_valid && req_ready;
    if (!rst_n) begin
      rd_cnt <= 0;
      wr_cnt <= 0;
      sweep_cnt <= 0;
    end else begin
      sweep_cnt <= sweep_cnt + 1;
      if (req_valid && req_ready) begin
        rd_cnt <= 0;
        wr_cnt <= 0;
      end else if (br_cmd_en) begin
        if (br_cmd.write) begin
          wr_cnt <= wr_cnt + 1;
        end else begin
          rd_cnt <= rd_cnt + 1;
        end
      end
    end
  end

  a_sweep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    sweep_cnt < 2**line_ix_w |-> !req_ready && !br_cmd_en)
    else begin
      $display("cache became active before the tag clear sweep ended");
      errors++;
    end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready && req.wstrb == '0 |-> rsp_rdata == exp_rdata)
    else begin
      $display("ERROR rsp_rdata expected %h got %h", exp_rdata, $sampled(rsp_rdata));
      errors++;
    end

  a_cmd_counts: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready |-> rd_cnt == exp_rd && wr_cnt == exp_wr)
    else begin
      $display("ERROR br_cmd_en count expected rd %h wr %h got rd %h wr %h",
               exp_rd, exp_wr, $sampled(rd_cnt), $sampled(wr_cnt));
      errors++;
    end

  a_cmd_addr: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> br_cmd.addr == (br_cmd.write ? exp_victim : exp_line))
    else begin
      $display("ERROR br_cmd.addr expected %h got %h",
               $sampled(br_cmd.write) ? exp_victim : exp_line, $sampled(br_cmd.addr));
      errors++;
    end

  // write-back goes out before the fill read
  a_cmd_order: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> (br_cmd.write ? (exp_wr == 1 && wr_cnt == 0 && rd_cnt == 0)
                                : (wr_cnt == exp_wr && rd_cnt == 0)))
    else begin
      $display("burst command came out of order or was not expected");
      errors++;
    end

  task automatic issue_request(input logic [31:0] addr, input word_t wdata, input strb_t wstrb);
    line_ix_t ix;
    tag_t tg;
    int unsigned w;
    logic hit;
    logic evict;
    word_t got;
    word_t want;
    ix = addr[10:5];
    tg = addr[20:11];
    w = int'(addr[20:2]);
    hit = shadow_valid[ix] && shadow_tag[ix] == tg;
    evict = !hit && shadow_valid[ix] && shadow_dirty[ix];
    exp_rd = hit ? 0 : 1;
    exp_wr = evict ? 1 : 0;
    exp_line = {tg, ix, 5'b0};
    exp_victim = {shadow_tag[ix], ix, 5'b0};
    exp_rdata = ref_word(w);
    req.addr = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    req_valid = 1'b1;
    do begin
      @(posedge clk);
      #5;
    end while (!accept_q);
    req_valid = 1'b0;
    if (!hit) begin
      shadow_valid[ix] = 1'b1;
      shadow_tag[ix] = tg;
      shadow_dirty[ix] = 1'b0;
    end
    if (wstrb != '0) begin
      shadow_dirty[ix] = 1'b1;
      ref_mem[w] = merge_bytes(ref_word(w), wdata, wstrb);
    end
    // written-back line must now sit in the RAM
    if (evict) begin
      for (int c = 0; c < col_count; c++) begin
        got = u_ram.peek_word(exp_victim + ram_addr_t'(4 * c));
        want = ref_word(int'(exp_victim[20:2]) + c);
        assert (got == want)
          else begin
            $display("ERROR ram word %h expected %h got %h",
                     exp_victim + ram_addr_t'(4 * c), want, got);
            errors++;
          end
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: FAILED", name);
    end
    errs_before = total_errors();
  endtask

  initial begin
    watch_run: begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired before all requests completed");
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] a;
    void'($urandom(93624));
    rst_n = 1'b0;
    req = '0;
    req_valid = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    errs_before = 0;
    for (int i = 0; i < 2**line_ix_w; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_dirty[i] = 1'b0;
      shadow_tag[i] = '0;
    end
    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // request waits through the clear sweep and then misses
    issue_request(32'h0000_0004, '0, '0);
    report_test("reset and first miss");
    issue_request({11'h0, 10'd1, 6'd1, 3'd3, 2'b0}, '0, '0);
    report_test("read miss");
    issue_request({11'h0, 10'd1, 6'd1, 3'd6, 2'b0}, '0, '0);
    report_test("read hit");
    a = {11'h0, 10'd1, 6'd1, 3'd5, 2'b0};
    issue_request(a, $urandom(), strb_t'($urandom_range(1, 15)));
    issue_request(a, '0, '0);
    report_test("byte masked write");
    issue_request({11'h0, 10'd2, 6'd1, 3'd5, 2'b0}, '0, '0);
    issue_request(a, '0, '0);
    report_test("dirty eviction");
    for (int n = 0; n < random_requests; n++) begin
      if ($urandom_range(0, 1) == 1) begin
        issue_request(random_address(), $urandom(), strb_t'($urandom_range(1, 15)));
      end else begin
        issue_request(random_address(), '0, '0);
      end
    end
    report_test("random mix and command spacing");

    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, total_errors());
    if (tests_bad == 0 && total_errors() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/burst_ram_model.sv */
// Burst RAM model
// Byte addressed burst RAM that moves one line as four 64-bit beats per
// command, answers reads after a fixed latency and checks command spacing

`default_nettype none

module burst_ram_model (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire burst_cache_pkg::br_cmd_t    br_cmd,
  input  wire                         br_cmd_en,
  input  wire burst_cache_pkg::beat_t      br_wr_data,
  input  wire [7:0]                   br_data_mask,
  output burst_cache_pkg::beat_t      br_rd_data,
  output logic                        br_rd_data_valid,
  output int                          spacing_errors
);
  import burst_cache_pkg::*;

  // cycles from the read command to the first beat
  localparam int read_latency = 6;

  word_t mem [int unsigned];
  int rd_timer;
  int rd_left;
  int wr_left;
  ram_addr_t rd_addr;
  ram_addr_t wr_addr;

  // untouched words hold a hash of their word address
  function automatic word_t prefill_word(input int unsigned w);
    return (w * 32'h9e3779b1) ^ (w << 11) ^ 32'h5a5a0000;
  endfunction

  function automatic word_t peek_word(input ram_addr_t a);
    int unsigned w;
    w = int'(a[ram_addr_w-1:2]);
    if (mem.exists(w)) begin
      return mem[w];
    end
    return prefill_word(w);
  endfunction

  task automatic store_beat(input ram_addr_t a, input beat_t beat);
    int unsigned w;
    w = int'(a[ram_addr_w-1:2]);
    mem[w] = beat[31:0];
    mem[w + 1] = beat[63:32];
  endtask

  initial begin
    spacing_errors = 0;
    br_rd_data_valid = 1'b0;
    br_rd_data = '0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      rd_timer <= 0;
      rd_left <= 0;
      wr_left <= 0;
      br_rd_data_valid <= 1'b0;
      br_rd_data <= '0;
    end else begin
      br_rd_data_valid <= 1'b0;
      // write beat 0 rides with the command
      if (br_cmd_en && br_cmd.write) begin
        store_beat(br_cmd.addr, br_wr_data);
        wr_addr <= br_cmd.addr + 8;
        wr_left <= beats_per_line - 1;
      end else if (wr_left != 0) begin
        store_beat(wr_addr, br_wr_data);
        wr_addr <= wr_addr + 8;
        wr_left <= wr_left - 1;
      end
      if (br_cmd_en && !br_cmd.write) begin
        rd_timer <= read_latency;
        rd_addr <= br_cmd.addr;
      end else if (rd_timer != 0) begin
        rd_timer <= rd_timer - 1;
        if (rd_timer == 1) begin
          rd_left <= beats_per_line;
        end
      end
      if (rd_left != 0) begin
        br_rd_data_valid <= 1'b1;
        br_rd_data <= {peek_word(rd_addr + 4), peek_word(rd_addr)};
        rd_addr <= rd_addr + 8;
        rd_left <= rd_left - 1;
      end
    end
  end

  a_cmd_gap: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en [*cmd_interval])
    else begin
      $display("burst command issued less than %0d cycles after the previous one",
               cmd_interval + 1);
      spacing_errors++;
    end

  a_mask_zero: assert property (@(posedge clk) disable iff (!rst_n)
    br_data_mask == '0)
    else begin
      $display("write data mask was not zero");
      spacing_errors++;
    end

endmodule

`default_nettype wire
